/* compile.f */
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_reg_file.sv
hw/rv_execute.sv
hw/rv_pipe_reg.sv
hw/rv_shared_mem.sv
hw/rv_core.sv
dv/rv_core_tb.sv

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;
   import rv_isa_pkg::*;
   import rv_pipe_pkg::*;

   logic        clk;
   logic        reset;
   mem_req_t    prog_req;
   logic        retire_valid;
   retire_t     retire;
   logic        halt;

   // program image, expected register writes and shadow state
   logic [31:0] prog [$];
   int          exp_rd [$];
   logic [31:0] exp_wd [$];
   logic [31:0] xr [32];
   logic [31:0] dmem [int];
   logic        skip;
   int          halt_pc;
   logic [31:0] rng_state = 32'd26;
   int          errors;
   int          tests_run;
   int          tests_failed;

   rv_core DUT (
      .clk(clk), .reset(reset), .prog_req_i(prog_req),
      .retire_valid_o(retire_valid), .retire_o(retire), .halt_o(halt)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // instruction encoders
   function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
      return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
   endfunction

   function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
   endfunction

   function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
   endfunction

   function automatic logic [31:0] enc_j(input int rd, input int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
   endfunction

   // integer results as the ISA defines them
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000:  return sub ? a - b : a + b;
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic new_program();
      prog.delete();
      exp_rd.delete();
      exp_wd.delete();
      dmem.delete();
      skip = 1'b0;
      foreach (xr[i]) begin
         xr[i] = '0;
      end
   endtask

   task automatic emit(input logic [31:0] word);
      prog.push_back(word);
   endtask

   task automatic expect_wr(input int rd, input logic [31:0] val);
      exp_rd.push_back(rd);
      exp_wd.push_back(val);
      if (rd != 0) begin
         xr[rd] = val;
      end
   endtask

   // wrong-path instructions are emitted with skip set
   task automatic imm_op(input logic [2:0] f3, input int rd, input int rs1, input int imm);
      logic [31:0] b;
      b = imm;
      emit(enc_i(op_imm, f3, rd, rs1, imm));
      if (!skip) begin
         expect_wr(rd, alu_ref(f3, 1'b0, xr[rs1], b));
      end
   endtask

   task automatic reg_op(input logic [2:0] f3, input logic sub, input int rd, input int rs1,
                         input int rs2);
      emit(enc_r(sub ? 7'b0100000 : 7'b0000000, f3, rd, rs1, rs2));
      if (!skip) begin
         expect_wr(rd, alu_ref(f3, sub, xr[rs1], xr[rs2]));
      end
   endtask

   task automatic lui_op(input int rd, input int imm20);
      emit({imm20[19:0], rd[4:0], op_lui});
      expect_wr(rd, {imm20[19:0], 12'h000});
   endtask

   task automatic lw_op(input int rd, input int rs1, input int off);
      int addr;
      addr = int'(xr[rs1]) + off;
      emit(enc_i(op_load, 3'b010, rd, rs1, off));
      if (!skip) begin
         expect_wr(rd, dmem[addr]);
      end
   endtask

   task automatic sw_op(input int rs2, input int rs1, input int off);
      int addr;
      addr = int'(xr[rs1]) + off;
      emit(enc_s(rs2, rs1, off));
      if (!skip) begin
         dmem[addr] = xr[rs2];
      end
   endtask

   task automatic jal_op(input int rd, input int off);
      logic [31:0] link;
      link = prog.size() * 4 + 4;
      emit(enc_j(rd, off));
      expect_wr(rd, link);
   endtask

   task automatic halt_op();
      halt_pc = prog.size() * 4;
      emit({12'd1, 5'd0, 3'b000, 5'd0, op_system});
   endtask

   // load under reset, a few nops past the end, then 3 idle reset cycles
   task automatic load_and_reset();
      reset = 1'b1;
      for (int i = 0; i < prog.size() + 4; i++) begin
         @(negedge clk);
         prog_req.valid = 1'b1;
         prog_req.write = 1'b1;
         prog_req.addr  = mem_addr_w'(i);
         if (i < prog.size()) begin
            prog_req.wdata = prog[i];
         end else begin
            prog_req.wdata = nop_instr;
         end
      end
      @(negedge clk);
      prog_req = '0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic run_and_check(input string name, input int max_cycles);
      int          got_rd [$];
      logic [31:0] got_wd [$];
      time         got_t [$];
      logic [31:0] last_pc;
      int          cycles;
      int          test_errs;
      int          n;
      cycles    = 0;
      test_errs = 0;
      last_pc   = '1;
      load_and_reset();
      while (!halt && cycles < max_cycles) begin
         @(negedge clk);
         cycles++;
         if (retire_valid) begin
            last_pc = retire.pc;
            if (retire.reg_write) begin
               got_rd.push_back(int'(retire.rd));
               got_wd.push_back(retire.wdata);
               got_t.push_back($time);
            end
         end
      end
      assert (halt) else begin
         $display("%s: halt_o never rose within %0d cycles", name, max_cycles);
         test_errs++;
      end
      // nothing may retire once halted
      repeat (5) begin
         @(negedge clk);
         assert (!retire_valid) else begin
            $display("[FAIL] %0t retire_valid_o got %b expected 0", $time, retire_valid);
            test_errs++;
         end
      end
      assert (last_pc == halt_pc) else begin
         $display("[FAIL] %0t retire_o.pc got %h expected %h", $time, last_pc, halt_pc);
         test_errs++;
      end
      assert (got_rd.size() == exp_rd.size()) else begin
         $display("%s: %0d register writes retired but %0d were expected",
                  name, got_rd.size(), exp_rd.size());
         test_errs++;
      end
      n = (got_rd.size() < exp_rd.size()) ? got_rd.size() : exp_rd.size();
      for (int i = 0; i < n; i++) begin
         assert (got_rd[i] == exp_rd[i]) else begin
            $display("[FAIL] %0t retire_o.rd got %0d expected %0d", got_t[i], got_rd[i],
                     exp_rd[i]);
            test_errs++;
         end
         assert (got_wd[i] == exp_wd[i]) else begin
            $display("[FAIL] %0t retire_o.wdata got %h expected %h", got_t[i], got_wd[i],
                     exp_wd[i]);
            test_errs++;
         end
      end
      $display("%-8s %s, %0d writes in %0d cycles", name, (test_errs == 0) ? "ok" : "FAILED",
               got_rd.size(), cycles);
      tests_run++;
      errors += test_errs;
      if (test_errs != 0) begin
         tests_failed++;
      end
   endtask

   // dependent chain hits both forwarding and the register file bypass
   task automatic test_alu();
      new_program();
      imm_op(3'b000, 1, 0, 100);
      imm_op(3'b000, 2, 1, -7);
      reg_op(3'b000, 1'b0, 3, 1, 2);
      reg_op(3'b000, 1'b1, 4, 3, 1);
      reg_op(3'b111, 1'b0, 5, 4, 3);
      reg_op(3'b110, 1'b0, 6, 5, 2);
      reg_op(3'b100, 1'b0, 7, 6, 1);
      reg_op(3'b010, 1'b0, 8, 2, 1);
      reg_op(3'b010, 1'b0, 9, 1, 2);
      imm_op(3'b100, 10, 7, -1);
      imm_op(3'b111, 11, 10, 'h0f0);
      imm_op(3'b110, 12, 11, 'h700);
      imm_op(3'b010, 13, 10, 0);
      imm_op(3'b010, 14, 1, -2048);
      lui_op(15, 'habcde);
      imm_op(3'b000, 15, 15, 'h123);
      halt_op();
      run_and_check("alu", 200);
   endtask

   task automatic test_mem();
      new_program();
      imm_op(3'b000, 1, 0, 'h400);
      imm_op(3'b000, 2, 0, -1234);
      sw_op(2, 1, 0);
      imm_op(3'b000, 3, 0, 555);
      sw_op(3, 1, 4);
      lw_op(4, 1, 0);
      reg_op(3'b000, 1'b0, 5, 4, 4);
      lw_op(6, 1, 4);
      reg_op(3'b000, 1'b1, 7, 6, 4);
      sw_op(7, 1, 8);
      lw_op(8, 1, 8);
      imm_op(3'b000, 9, 8, 1);
      halt_op();
      run_and_check("mem", 200);
   endtask

   task automatic test_branch();
      new_program();
      imm_op(3'b000, 1, 0, 5);
      imm_op(3'b000, 2, 0, 5);
      emit(enc_b(3'b000, 1, 2, 12));
      skip = 1'b1;
      imm_op(3'b000, 10, 0, 1);
      imm_op(3'b000, 11, 0, 1);
      skip = 1'b0;
      imm_op(3'b000, 3, 0, 7);
      // not taken, falls through to x4
      emit(enc_b(3'b000, 3, 1, 8));
      imm_op(3'b000, 4, 0, 9);
      emit(enc_b(3'b001, 4, 1, 12));
      skip = 1'b1;
      imm_op(3'b000, 12, 0, 1);
      imm_op(3'b000, 13, 0, 1);
      skip = 1'b0;
      imm_op(3'b000, 5, 4, 1);
      halt_op();
      run_and_check("branch", 200);
   endtask

   task automatic test_jal();
      new_program();
      imm_op(3'b000, 1, 0, 3);
      jal_op(5, 12);
      skip = 1'b1;
      imm_op(3'b000, 6, 0, 1);
      imm_op(3'b000, 7, 0, 1);
      skip = 1'b0;
      reg_op(3'b000, 1'b0, 2, 5, 1);
      halt_op();
      run_and_check("jal", 200);
   endtask

   // x0 reads at distances one, two and three behind the writes
   task automatic test_x0_halt();
      new_program();
      imm_op(3'b000, 0, 0, 5);
      reg_op(3'b000, 1'b0, 1, 0, 0);
      imm_op(3'b000, 0, 1, 77);
      imm_op(3'b000, 2, 0, 0);
      imm_op(3'b110, 3, 0, 0);
      halt_op();
      skip = 1'b1;
      imm_op(3'b000, 9, 0, 1);
      skip = 1'b0;
      run_and_check("x0_halt", 200);
   endtask

   task automatic test_random();
      logic [31:0] r;
      logic [31:0] imm;
      logic [31:0] sum;
      new_program();
      sum = '0;
      for (int k = 0; k < 20; k++) begin
         r   = xorshift();
         imm = {{20{r[11]}}, r[11:0]};
         sum = sum + imm;
         emit(enc_i(op_imm, 3'b000, 1, (k == 0) ? 0 : 1, int'(imm)));
         expect_wr(1, sum);
      end
      halt_op();
      run_and_check("random", 200);
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      prog_req     = '0;
      skip         = 1'b0;
      halt_pc      = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_alu();
      test_mem();
      test_branch();
      test_jal();
      test_x0_halt();
      test_random();
      $display("%0d tests run, %0d failed, %0d checks failed", tests_run, tests_failed,
               errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_pipe_pkg::mem_req_t prog_req_i,
   output logic                  retire_valid_o,
   output rv_pipe_pkg::retire_t  retire_o,
   output logic                  halt_o
);
   import rv_isa_pkg::*;
   import rv_pipe_pkg::*;

   mem_req_t              fetch_req, data_req;
   logic [xlen-1:0]       fetch_rdata, data_rdata;
   logic                  fetch_gnt, fetch_valid;
   fd_t                   fetch_fd, fd_q;
   de_t                   dec_de, de_q;
   em_t                   exe_em, em_q;
   logic                  fd_valid, de_valid, em_valid;
   logic [reg_addr_w-1:0] dec_rs1, dec_rs2;
   logic [xlen-1:0]       rs1_val, rs2_val;
   logic [xlen-1:0]       op_a, op_b, wb_data, target;
   logic                  exe_redirect, redirect, fwd_ok, halt_now, squash;

   // taken branch or jump out of a valid execute slot
   assign redirect = de_valid & exe_redirect;
   assign halt_now = em_valid & em_q.ctrl.halt;
   assign squash   = halt_now | halt_o;

   always_ff @(posedge clk) begin
      if (reset) begin
         halt_o <= 1'b0;
      end else if (halt_now) begin
         halt_o <= 1'b1;
      end
   end

   rv_fetch u_fetch (
      .clk(clk), .reset(reset), .redirect_i(redirect), .target_i(target),
      .gnt_i(fetch_gnt), .halt_i(halt_o), .rdata_i(fetch_rdata),
      .req_o(fetch_req), .fd_o(fetch_fd), .valid_o(fetch_valid)
   );

   rv_pipe_reg #(.payload_t(fd_t)) u_fd_reg (
      .clk(clk), .reset(reset), .flush_i(redirect | squash), .valid_i(fetch_valid),
      .data_i(fetch_fd), .valid_o(fd_valid), .data_o(fd_q)
   );

   rv_decode u_decode (
      .fd_i(fd_q), .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
      .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(), .imm_o(), .ctrl_o(), .de_o(dec_de)
   );

   rv_reg_file u_reg_file (
      .clk(clk), .reset(reset), .rs1_i(dec_rs1), .rs2_i(dec_rs2), .rd_i(em_q.rd),
      .we_i(em_valid & em_q.ctrl.reg_write), .wdata_i(wb_data),
      .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
   );

   rv_pipe_reg #(.payload_t(de_t)) u_de_reg (
      .clk(clk), .reset(reset), .flush_i(redirect | squash), .valid_i(fd_valid),
      .data_i(dec_de), .valid_o(de_valid), .data_o(de_q)
   );

   // forward from memory/writeback, load data included
   assign fwd_ok = em_valid & em_q.ctrl.reg_write & (em_q.rd != '0);
   assign op_a   = (fwd_ok && em_q.rd == de_q.rs1) ? wb_data : de_q.rs1_val;
   assign op_b   = (fwd_ok && em_q.rd == de_q.rs2) ? wb_data : de_q.rs2_val;

   rv_execute u_execute (
      .de_i(de_q), .op_a_i(op_a), .op_b_i(op_b),
      .em_o(exe_em), .redirect_o(exe_redirect), .target_o(target)
   );

   rv_pipe_reg #(.payload_t(em_t)) u_em_reg (
      .clk(clk), .reset(reset), .flush_i(squash), .valid_i(de_valid),
      .data_i(exe_em), .valid_o(em_valid), .data_o(em_q)
   );

   // load/store takes the memory ahead of fetch
   assign data_req.valid = em_valid & (em_q.ctrl.mem_read | em_q.ctrl.mem_write);
   assign data_req.write = em_q.ctrl.mem_write;
   assign data_req.addr  = em_q.result[mem_addr_w+1:2];
   assign data_req.wdata = em_q.store_data;

   rv_shared_mem u_mem (
      .clk(clk), .reset(reset), .prog_req_i(prog_req_i), .data_req_i(data_req),
      .fetch_req_i(fetch_req), .data_rdata_o(data_rdata), .fetch_rdata_o(fetch_rdata),
      .fetch_gnt_o(fetch_gnt)
   );

   assign wb_data = em_q.ctrl.mem_read ? data_rdata : em_q.result;

   assign retire_valid_o = em_valid;
   assign retire_o       = '{pc: em_q.pc, rd: em_q.rd, wdata: wb_data,
                             reg_write: em_q.ctrl.reg_write};

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode (
   input  rv_pipe_pkg::fd_t                  fd_i,
   input  logic [rv_isa_pkg::xlen-1:0]       rs1_val_i,
   input  logic [rv_isa_pkg::xlen-1:0]       rs2_val_i,
   output logic [rv_isa_pkg::reg_addr_w-1:0] rs1_o,
   output logic [rv_isa_pkg::reg_addr_w-1:0] rs2_o,
   output logic [rv_isa_pkg::reg_addr_w-1:0] rd_o,
   output logic [rv_isa_pkg::xlen-1:0]       imm_o,
   output rv_pipe_pkg::ctrl_t                ctrl_o,
   output rv_pipe_pkg::de_t                  de_o
);
   import rv_isa_pkg::*;

   logic [xlen-1:0] instr;
   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
   logic            f3_ok;
   alu_op_e         f3_op;

   assign instr  = fd_i.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1_o  = instr[19:15];
   assign rs2_o  = instr[24:20];
   assign rd_o   = instr[11:7];

   // immediates, all sign extended from bit 31
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // alu op shared by the immediate and register forms
   always_comb begin
      f3_ok = 1'b1;
      f3_op = alu_add;
      case (funct3)
         f3_add_sub: f3_op = alu_add;
         f3_slt:     f3_op = alu_slt;
         f3_xor:     f3_op = alu_xor;
         f3_or:      f3_op = alu_or;
         f3_and:     f3_op = alu_and;
         default:    f3_ok = 1'b0;
      endcase
   end

   // anything not recognized stays a no-op
   always_comb begin
      ctrl_o        = '0;
      ctrl_o.alu_op = alu_add;
      imm_o         = imm_i;
      case (opcode)
         op_lui: begin
            ctrl_o.alu_op    = alu_pass_b;
            ctrl_o.is_lui    = 1'b1;
            ctrl_o.reg_write = 1'b1;
            imm_o            = imm_u;
         end
         op_jal: begin
            ctrl_o.jump      = 1'b1;
            ctrl_o.reg_write = 1'b1;
            imm_o            = imm_j;
         end
         op_branch: begin
            ctrl_o.branch    = (funct3 == f3_beq) || (funct3 == f3_bne);
            ctrl_o.branch_ne = (funct3 == f3_bne);
            imm_o            = imm_b;
         end
         op_load: begin
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.mem_read  = (funct3 == f3_lw);
            ctrl_o.reg_write = (funct3 == f3_lw);
         end
         op_store: begin
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.mem_write = (funct3 == f3_lw);
            imm_o            = imm_s;
         end
         op_imm: begin
            ctrl_o.alu_op    = f3_op;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.reg_write = f3_ok;
         end
         op_reg: begin
            if (funct7 == f7_sub && funct3 == f3_add_sub) begin
               ctrl_o.alu_op    = alu_sub;
               ctrl_o.reg_write = 1'b1;
            end else if (funct7 == f7_base) begin
               ctrl_o.alu_op    = f3_op;
               ctrl_o.reg_write = f3_ok;
            end
         end
         op_system: begin
            ctrl_o.halt = (instr == ebreak_instr);
         end
         default: ;
      endcase
   end

   // payload for the decode/execute register
   assign de_o = '{pc: fd_i.pc, rs1: rs1_o, rs2: rs2_o, rd: rd_o,
                   rs1_val: rs1_val_i, rs2_val: rs2_val_i, imm: imm_o, ctrl: ctrl_o};

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute (
   input  rv_pipe_pkg::de_t            de_i,
   input  logic [rv_isa_pkg::xlen-1:0] op_a_i,
   input  logic [rv_isa_pkg::xlen-1:0] op_b_i,
   output rv_pipe_pkg::em_t            em_o,
   output logic                        redirect_o,
   output logic [rv_isa_pkg::xlen-1:0] target_o
);
   import rv_isa_pkg::*;

   logic [xlen-1:0] alu_b;
   logic [xlen-1:0] alu_res;
   logic [xlen-1:0] link;
   logic            equal;

   // lui passes its upper immediate through the alu
   assign alu_b = (de_i.ctrl.use_imm | de_i.ctrl.is_lui) ? de_i.imm : op_b_i;

   always_comb begin
      case (de_i.ctrl.alu_op)
         alu_add:    alu_res = op_a_i + alu_b;
         alu_sub:    alu_res = op_a_i - alu_b;
         alu_and:    alu_res = op_a_i & alu_b;
         alu_or:     alu_res = op_a_i | alu_b;
         alu_xor:    alu_res = op_a_i ^ alu_b;
         alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a_i) < $signed(alu_b)};
         alu_pass_b: alu_res = alu_b;
         default:    alu_res = '0;
      endcase
   end

   // branch resolution, only beq and bne exist
   assign equal      = (op_a_i == op_b_i);
   assign redirect_o = de_i.ctrl.jump | (de_i.ctrl.branch & (equal ^ de_i.ctrl.branch_ne));
   assign target_o   = de_i.pc + de_i.imm;
   assign link       = de_i.pc + xlen'(4);

   assign em_o.pc         = de_i.pc;
   assign em_o.rd         = de_i.rd;
   assign em_o.store_data = op_b_i;
   assign em_o.ctrl       = de_i.ctrl;

   // jal links, everything else comes out of the alu
   assign em_o.result = de_i.ctrl.jump ? link : alu_res;

endmodule

/* hw/rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        redirect_i,
   input  logic [rv_isa_pkg::xlen-1:0] target_i,
   input  logic                        gnt_i,
   input  logic                        halt_i,
   input  logic [rv_isa_pkg::xlen-1:0] rdata_i,
   output rv_pipe_pkg::mem_req_t       req_o,
   output rv_pipe_pkg::fd_t            fd_o,
   output logic                        valid_o
);
   import rv_isa_pkg::*;

   logic [xlen-1:0] pc_q;

   // redirect wins, otherwise step only on a granted fetch
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= reset_pc;
      end else if (redirect_i) begin
         pc_q <= target_i;
      end else if (gnt_i) begin
         pc_q <= pc_q + xlen'(4);
      end
   end

   assign req_o.valid = ~halt_i;
   assign req_o.write = 1'b0;
   assign req_o.addr  = pc_q[mem_addr_w+1:2];
   assign req_o.wdata = '0;

   // a lost fetch turns into a bubble
   assign valid_o    = gnt_i;
   assign fd_o.pc    = pc_q;
   assign fd_o.instr = gnt_i ? rdata_i : nop_instr;

   // branch and jump targets from execute must keep the pc on a word
   a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00);

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

   // architectural sizes
   localparam int xlen       = 32;
   localparam int reg_addr_w = 5;
   localparam int mem_words  = 1024;
   localparam int mem_addr_w = 10;

   localparam logic [xlen-1:0] reset_pc = '0;

   // major opcodes of the supported subset
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;
   localparam logic [6:0] op_system = 7'b1110011;

   // funct3 values
   localparam logic [2:0] f3_beq     = 3'b000;
   localparam logic [2:0] f3_bne     = 3'b001;
   localparam logic [2:0] f3_lw      = 3'b010;
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;

   // funct7 values for register-register ops
   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_sub  = 7'b0100000;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_pass_b
   } alu_op_e;

   // addi x0, x0, 0
   localparam logic [xlen-1:0] nop_instr    = 32'h0000_0013;
   localparam logic [xlen-1:0] ebreak_instr = 32'h0010_0073;

endpackage

/* hw/rv_pipe_pkg.sv */
package rv_pipe_pkg;

   import rv_isa_pkg::*;

   // decoded control word
   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    branch;
      logic    branch_ne;
      logic    jump;
      logic    is_lui;
      logic    halt;
   } ctrl_t;

   // fetch to decode
   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [xlen-1:0] instr;
   } fd_t;

   // decode to execute
   typedef struct packed {
      logic [xlen-1:0]       pc;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       rs1_val;
      logic [xlen-1:0]       rs2_val;
      logic [xlen-1:0]       imm;
      ctrl_t                 ctrl;
   } de_t;

   // execute to memory/writeback
   typedef struct packed {
      logic [xlen-1:0]       pc;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       result;
      logic [xlen-1:0]       store_data;
      ctrl_t                 ctrl;
   } em_t;

   // one request on a port of the shared memory
   typedef struct packed {
      logic                  valid;
      logic                  write;
      logic [mem_addr_w-1:0] addr;
      logic [xlen-1:0]       wdata;
   } mem_req_t;

   typedef struct packed {
      logic [xlen-1:0]       pc;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       wdata;
      logic                  reg_write;
   } retire_t;

endpackage

/* hw/rv_pipe_reg.sv */
`timescale 1ns/1ns

module rv_pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     flush_i,
   input  logic     valid_i,
   input  payload_t data_i,
   output logic     valid_o,
   output payload_t data_o
);

   // reset or flush empties the slot
   always_ff @(posedge clk) begin
      if (reset || flush_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      data_o <= data_i;
   end

   // upstream stages must never hand over an unknown valid
   a_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(valid_o));

endmodule

/* hw/rv_reg_file.sv */
`timescale 1ns/1ns

module rv_reg_file (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1_i,
   input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2_i,
   input  logic [rv_isa_pkg::reg_addr_w-1:0] rd_i,
   input  logic                              we_i,
   input  logic [rv_isa_pkg::xlen-1:0]       wdata_i,
   output logic [rv_isa_pkg::xlen-1:0]       rs1_val_o,
   output logic [rv_isa_pkg::xlen-1:0]       rs2_val_o
);
   import rv_isa_pkg::*;

   // x0 has no storage
   logic [xlen-1:0] regs [1:31];

   function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] idx);
      if (idx == '0) begin
         return '0;
      end else if (we_i && rd_i == idx) begin
         // writer two ahead of the reader
         return wdata_i;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   always_comb begin
      rs1_val_o = read_port(rs1_i);
      rs2_val_o = read_port(rs2_i);
   end

endmodule

/* hw/rv_shared_mem.sv */
`timescale 1ns/1ns

module rv_shared_mem (
   input  logic                        clk,
   input  logic                        reset,
   input  rv_pipe_pkg::mem_req_t       prog_req_i,
   input  rv_pipe_pkg::mem_req_t       data_req_i,
   input  rv_pipe_pkg::mem_req_t       fetch_req_i,
   output logic [rv_isa_pkg::xlen-1:0] data_rdata_o,
   output logic [rv_isa_pkg::xlen-1:0] fetch_rdata_o,
   output logic                        fetch_gnt_o
);
   import rv_isa_pkg::*;
   import rv_pipe_pkg::*;

   logic [xlen-1:0] mem [mem_words];
   mem_req_t        sel;
   logic [xlen-1:0] rdata;

   // fixed priority: program load, data, fetch
   always_comb begin
      if (prog_req_i.valid) begin
         sel = prog_req_i;
      end else if (data_req_i.valid) begin
         sel = data_req_i;
      end else begin
         sel = fetch_req_i;
      end
   end

   always_ff @(posedge clk) begin
      if (sel.valid && sel.write) begin
         mem[sel.addr] <= sel.wdata;
      end
   end

   // one read per cycle, returned to whichever port won
   assign rdata         = mem[sel.addr];
   assign data_rdata_o  = rdata;
   assign fetch_rdata_o = rdata;
   assign fetch_gnt_o   = fetch_req_i.valid & ~prog_req_i.valid & ~data_req_i.valid;

   // program loading is confined to reset
   a_prog_in_reset: assert property (@(posedge clk) prog_req_i.valid |-> reset);

   // so a load/store from the core never collides with it
   a_no_data_prog: assert property (@(posedge clk) data_req_i.valid |-> !prog_req_i.valid);

endmodule

/* run.sh */
#!/bin/sh
# build the core and testbench with Verilator, run, then judge the log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module rv_core_tb \
   -o rv_core_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || grep -q "Done: no errors" sim.log
